/* design/rom_pkg.sv */
// rom access package: slot geometry, sdram address width and the rom word views
`default_nettype none

package rom_pkg;

    // sdram side, addresses count 32-bit words
    localparam int SDRAM_AW = 22;
    localparam int SLOT_N   = 4;

    // item width per slot
    localparam int SLOT0_DW = 8;
    localparam int SLOT1_DW = 16;
    localparam int SLOT2_DW = 32;
    localparam int SLOT3_DW = 8;

    // slot address widths, in items
    localparam int SLOT0_AW = 12;
    localparam int SLOT1_AW = 11;
    localparam int SLOT2_AW = 10;
    localparam int SLOT3_AW = 12;

    // each slot lives in its own sdram region
    localparam logic [SDRAM_AW-1:0] SLOT0_OFFSET = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] SLOT1_OFFSET = 22'h01_0000;
    localparam logic [SDRAM_AW-1:0] SLOT2_OFFSET = 22'h02_0000;
    localparam logic [SDRAM_AW-1:0] SLOT3_OFFSET = 22'h03_0000;

    // one fetched 32-bit word, read as bytes or as halfwords
    // lane 0 is the least significant lane in both views
    typedef union packed {
        logic [3:0][7:0]  bytes;  // bytes[0] = bits 7:0
        logic [1:0][15:0] halves; // halves[0] = bits 15:0
    } rom_word_t;

endpackage : rom_pkg

`default_nettype wire

/* design/rom_slot_if.sv */
// slot link: miss request from one slot and the fill/flush path back from the arbiter
`default_nettype none

interface rom_slot_if import rom_pkg::*; ();

    logic                req;       // slot has a miss
    logic [SDRAM_AW-1:0] word_addr; // sdram word the slot wants
    logic                fill;      // one-cycle write strobe
    logic [31:0]         fill_data;
    logic                flush;     // invalidate, level

    modport requester (
        output req, word_addr,
        input  fill, fill_data, flush
    );

    modport arbiter (
        input  req, word_addr,
        output fill, fill_data, flush
    );

endinterface : rom_slot_if

`default_nettype wire

/* design/rom_slot_req.sv */
// rom slot requester: one-word cache, hit check, lane select and miss request
`default_nettype none

module rom_slot_req import rom_pkg::*; #(
    parameter int                  DW     = 8,  // item width, 8, 16 or 32
    parameter int                  AW     = 12, // address width in items
    parameter logic [SDRAM_AW-1:0] OFFSET = '0  // slot base, in words
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] dout,
    output logic          ok,
    rom_slot_if.requester link
);

    rom_word_t           cache;     // last word fetched for this slot
    logic [SDRAM_AW-1:0] tag;       // its sdram word address
    logic                valid;
    logic [SDRAM_AW-1:0] word_addr; // word holding the current item
    logic                hit;

    // word address and lane select depend on the item width
    generate
        if (DW == 8) begin : g_byte
            // four items per word
            assign word_addr = OFFSET + SDRAM_AW'(addr[AW-1:2]);
            assign dout      = cache.bytes[addr[1:0]];
        end else if (DW == 16) begin : g_half
            // two items per word
            assign word_addr = OFFSET + SDRAM_AW'(addr[AW-1:1]);
            assign dout      = cache.halves[addr[0]];
        end else begin : g_word
            // one item is the whole word
            assign word_addr = OFFSET + SDRAM_AW'(addr);
            assign dout      = cache;
        end
    endgenerate

    assign hit = valid && (tag == word_addr);

    // hit answers in the same cycle
    assign ok = cs && hit;

    // a miss asks the arbiter for the word
    assign link.req       = cs && !hit;
    assign link.word_addr = word_addr;

    // valid bit, flush wins over a fill in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (link.flush) begin
            valid <= 1'b0;
        end else if (link.fill) begin
            valid <= 1'b1;
        end
    end

    // cached word and tag
    always_ff @(posedge clk) begin
        if (link.fill) begin
            cache <= link.fill_data;
            tag   <= word_addr; // address is held until ok
        end
    end

endmodule : rom_slot_req

`default_nettype wire

/* design/rom_slot_arbiter.sv */
// fixed-priority rom arbiter: one sdram read at a time, fill steering and refresh enable
`default_nettype none

module rom_slot_arbiter import rom_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic                loop_rst,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [31:0]         data_read,
    output logic                sdram_req,
    output logic                refresh_en,
    output logic [SDRAM_AW-1:0] sdram_addr,
    rom_slot_if.arbiter         slot0,
    rom_slot_if.arbiter         slot1,
    rom_slot_if.arbiter         slot2,
    rom_slot_if.arbiter         slot3
);

    logic [SLOT_N-1:0]   req;
    logic [SDRAM_AW-1:0] addr_req [SLOT_N];
    logic [SLOT_N-1:0]   sel;    // one-hot, slot being served
    logic [SLOT_N-1:0]   active; // waiting and not in service
    logic [SLOT_N-1:0]   grant;
    logic [SDRAM_AW-1:0] grant_addr;
    logic                accept; // free to take a new request
    logic                flush;

    assign req = {slot3.req, slot2.req, slot1.req, slot0.req};

    assign addr_req[0] = slot0.word_addr;
    assign addr_req[1] = slot1.word_addr;
    assign addr_req[2] = slot2.word_addr;
    assign addr_req[3] = slot3.word_addr;

    // served slot still shows req in its fill cycle
    assign active = req & ~sel;
    assign accept = (sel == '0) || data_rdy;
    assign flush  = downloading || loop_rst;

    // lowest slot number wins
    always_comb begin
        grant      = '0;
        grant_addr = '0;
        for (int i = SLOT_N - 1; i >= 0; i--) begin
            if (active[i]) begin
                grant      = '0;
                grant[i]   = 1'b1;
                grant_addr = addr_req[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            sdram_req <= 1'b0; // pending read is dropped
            sel       <= '0;
        end else begin
            if (sdram_ack) sdram_req <= 1'b0;
            if (accept) begin
                sdram_req <= |active;
                sel       <= grant;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && |active) sdram_addr <= grant_addr;
    end

    // every slot satisfied, controller may refresh
    always_ff @(posedge clk) begin
        if (!rst_n) refresh_en <= 1'b0;
        else        refresh_en <= ~|req;
    end

    // returned word goes to the selected slot only
    assign slot0.fill = data_rdy && sel[0];
    assign slot1.fill = data_rdy && sel[1];
    assign slot2.fill = data_rdy && sel[2];
    assign slot3.fill = data_rdy && sel[3];

    assign slot0.fill_data = data_read;
    assign slot1.fill_data = data_read;
    assign slot2.fill_data = data_read;
    assign slot3.fill_data = data_read;

    assign slot0.flush = flush;
    assign slot1.flush = flush;
    assign slot2.flush = flush;
    assign slot3.flush = flush;

endmodule : rom_slot_arbiter

`default_nettype wire

/* design/rom_access.sv */
// rom access top: four cached rom slots sharing one sdram controller
`default_nettype none

module rom_access import rom_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic                loop_rst,

    // sdram controller
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [31:0]         data_read,
    output logic                sdram_req,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic                refresh_en,

    // slot 0, highest priority
    input  logic                slot0_cs,
    input  logic [SLOT0_AW-1:0] slot0_addr,
    output logic [SLOT0_DW-1:0] slot0_dout,
    output logic                slot0_ok,

    input  logic                slot1_cs,
    input  logic [SLOT1_AW-1:0] slot1_addr,
    output logic [SLOT1_DW-1:0] slot1_dout,
    output logic                slot1_ok,

    input  logic                slot2_cs,
    input  logic [SLOT2_AW-1:0] slot2_addr,
    output logic [SLOT2_DW-1:0] slot2_dout,
    output logic                slot2_ok,

    // slot 3, lowest priority
    input  logic                slot3_cs,
    input  logic [SLOT3_AW-1:0] slot3_addr,
    output logic [SLOT3_DW-1:0] slot3_dout,
    output logic                slot3_ok
);

    rom_slot_if link [SLOT_N] ();

    rom_slot_req #(
        .DW     (SLOT0_DW),
        .AW     (SLOT0_AW),
        .OFFSET (SLOT0_OFFSET)
    ) u_slot0 (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (slot0_cs),
        .addr  (slot0_addr),
        .dout  (slot0_dout),
        .ok    (slot0_ok),
        .link  (link[0])
    );

    rom_slot_req #(
        .DW     (SLOT1_DW),
        .AW     (SLOT1_AW),
        .OFFSET (SLOT1_OFFSET)
    ) u_slot1 (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (slot1_cs),
        .addr  (slot1_addr),
        .dout  (slot1_dout),
        .ok    (slot1_ok),
        .link  (link[1])
    );

    rom_slot_req #(
        .DW     (SLOT2_DW),
        .AW     (SLOT2_AW),
        .OFFSET (SLOT2_OFFSET)
    ) u_slot2 (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (slot2_cs),
        .addr  (slot2_addr),
        .dout  (slot2_dout),
        .ok    (slot2_ok),
        .link  (link[2])
    );

    rom_slot_req #(
        .DW     (SLOT3_DW),
        .AW     (SLOT3_AW),
        .OFFSET (SLOT3_OFFSET)
    ) u_slot3 (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (slot3_cs),
        .addr  (slot3_addr),
        .dout  (slot3_dout),
        .ok    (slot3_ok),
        .link  (link[3])
    );

    // one read in flight, slot 0 first
    rom_slot_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .sdram_req   (sdram_req),
        .refresh_en  (refresh_en),
        .sdram_addr  (sdram_addr),
        .slot0       (link[0]),
        .slot1       (link[1]),
        .slot2       (link[2]),
        .slot3       (link[3])
    );

endmodule : rom_access

`default_nettype wire

/* testbench/tb_sdram_responder.sv */
// sdram controller model: acks each read and returns a pattern word after random delays
`default_nettype none

module tb_sdram_responder import rom_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                slow,      // force the longest delays
    input  logic                sdram_req,
    input  logic [SDRAM_AW-1:0] sdram_addr,
    output logic                sdram_ack,
    output logic                data_rdy,
    output logic [31:0]         data_read,
    output logic                busy       // a read is in progress
);

    logic [SDRAM_AW-1:0] addr_q;
    int                  ack_dly;
    int                  data_dly;

    // sdram contents, every word address gives its own word
    function automatic logic [31:0] pattern(input logic [SDRAM_AW-1:0] a);
        logic [31:0] x;
        x = {10'h0, a};
        return (x * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        busy      = 1'b0;
        addr_q    = '0;
        forever begin
            @(posedge clk);
            if (rst_n && sdram_req) begin
                addr_q   = sdram_addr;
                ack_dly  = slow ? 3 : int'($urandom_range(3, 1));
                data_dly = slow ? 6 : int'($urandom_range(6, 2));
                #1;
                busy = 1'b1;
                repeat (ack_dly - 1) @(posedge clk);
                #1;
                sdram_ack = 1'b1;
                @(posedge clk);
                #1;
                sdram_ack = 1'b0;
                repeat (data_dly - 1) @(posedge clk);
                #1;
                data_rdy  = 1'b1;
                data_read = pattern(addr_q);
                @(posedge clk);
                #1;
                data_rdy = 1'b0;
                busy     = 1'b0;
            end
        end
    end

endmodule : tb_sdram_responder

`default_nettype wire

/* testbench/tb_rom_access.sv */
// rom access testbench with random slot traffic checked against a cache and priority model
`default_nettype none

module tb_rom_access import rom_pkg::*; ();

    localparam int N_TRANS    = 240;                     // upper bound on reads over the run
    localparam int MAX_CYCLES = N_TRANS * 4 * 10 + 2000; // four queued slots of ten cycles each
    localparam int DW_TAB [4] = '{SLOT0_DW, SLOT1_DW, SLOT2_DW, SLOT3_DW};
    localparam int AW_TAB [4] = '{SLOT0_AW, SLOT1_AW, SLOT2_AW, SLOT3_AW};
    localparam logic [SDRAM_AW-1:0] OFS_TAB [4] = '{SLOT0_OFFSET, SLOT1_OFFSET,
                                                    SLOT2_OFFSET, SLOT3_OFFSET};

    logic                clk = 1'b0;
    logic                rst_n;
    logic                downloading;
    logic                loop_rst;
    logic                slow;
    logic                busy;
    logic                sdram_req;
    logic                sdram_ack;
    logic                data_rdy;
    logic [31:0]         data_read;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic                refresh_en;
    logic [3:0]          cs;
    logic [3:0]          ok;
    logic [11:0]         addr [4]; // narrow slots use the low bits
    logic [31:0]         dout [4];
    logic [SLOT0_DW-1:0] dout0;
    logic [SLOT1_DW-1:0] dout1;
    logic [SLOT2_DW-1:0] dout2;
    logic [SLOT3_DW-1:0] dout3;

    // reference model state
    logic [3:0]          model_valid;
    logic [SDRAM_AW-1:0] model_tag [4];
    logic [SDRAM_AW-1:0] issued_addr;
    logic [SDRAM_AW-1:0] issued_q [$]; // every read address in issue order
    logic                req_q;
    logic                outstanding;
    logic                primed;
    logic                miss_q;
    int                  req_count = 0;
    int                  cycles = 0;

    rom_access dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .slot0_cs    (cs[0]),
        .slot0_addr  (addr[0][SLOT0_AW-1:0]),
        .slot0_dout  (dout0),
        .slot0_ok    (ok[0]),
        .slot1_cs    (cs[1]),
        .slot1_addr  (addr[1][SLOT1_AW-1:0]),
        .slot1_dout  (dout1),
        .slot1_ok    (ok[1]),
        .slot2_cs    (cs[2]),
        .slot2_addr  (addr[2][SLOT2_AW-1:0]),
        .slot2_dout  (dout2),
        .slot2_ok    (ok[2]),
        .slot3_cs    (cs[3]),
        .slot3_addr  (addr[3][SLOT3_AW-1:0]),
        .slot3_dout  (dout3),
        .slot3_ok    (ok[3])
    );

    tb_sdram_responder u_sdram (
        .clk        (clk),
        .rst_n      (rst_n),
        .slow       (slow),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read),
        .busy       (busy)
    );

    assign dout[0] = 32'(dout0);
    assign dout[1] = 32'(dout1);
    assign dout[2] = 32'(dout2);
    assign dout[3] = 32'(dout3);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: slots still waiting after %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // expected sdram contents
    function automatic logic [31:0] pattern(input logic [SDRAM_AW-1:0] a);
        logic [31:0] x;
        x = {10'h0, a};
        return (x * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // 32/DW items share one sdram word
    function automatic logic [SDRAM_AW-1:0] word_of(input int s, input logic [11:0] a);
        return OFS_TAB[s] + SDRAM_AW'(a / 12'(32 / DW_TAB[s]));
    endfunction

    function automatic logic [11:0] lane_mask(input int s);
        return 12'(32 / DW_TAB[s] - 1);
    endfunction

    function automatic logic [11:0] rand_addr(input int s);
        return 12'($urandom) & 12'((1 << AW_TAB[s]) - 1);
    endfunction

    function automatic logic model_hit(input int s, input logic [11:0] a);
        return model_valid[s] && (model_tag[s] == word_of(s, a));
    endfunction

    function automatic logic [31:0] expect_dout(input int s, input logic [11:0] a);
        rom_word_t w;
        w = pattern(word_of(s, a));
        if (DW_TAB[s] == 8)
            return 32'(w.bytes[a[1:0]]);
        if (DW_TAB[s] == 16)
            return 32'(w.halves[a[0]]);
        return w;
    endfunction

    // model update and checks at each rising edge
    always @(posedge clk) begin
        logic miss_now;
        int   fill_slot;
        miss_now = 1'b0;
        if (!rst_n) begin
            model_valid = '0;
            req_q       = 1'b0;
            outstanding = 1'b0;
            primed      = 1'b0;
        end else begin
            for (int s = 0; s < 4; s++) begin
                miss_now = miss_now || (cs[s] && !model_hit(s, addr[s]));
                check_eq("slot ok", 32'(cs[s] && model_hit(s, addr[s])), 32'(ok[s]));
                if (ok[s])
                    check_eq("slot dout", expect_dout(s, addr[s]), dout[s]);
            end
            if (primed)
                check_eq("refresh_en", 32'(!miss_q), 32'(refresh_en));
            if (sdram_req && !req_q) begin
                check_eq("one read outstanding", 32'(0), 32'(outstanding));
                outstanding = 1'b1;
                issued_addr = sdram_addr;
                issued_q.push_back(sdram_addr);
                req_count++;
            end else if (sdram_req) begin
                check_eq("sdram_addr held", 32'(issued_addr), 32'(sdram_addr));
            end
            if (data_rdy) begin
                fill_slot = int'(issued_addr[17:16]); // region picks the slot
                check_eq("fill address", 32'(word_of(fill_slot, addr[fill_slot])),
                         32'(issued_addr));
                outstanding            = 1'b0;
                model_tag[fill_slot]   = issued_addr;
                model_valid[fill_slot] = 1'b1;
            end
            if (downloading || loop_rst)
                model_valid = '0;
            req_q  = sdram_req;
            miss_q = miss_now;
            primed = 1'b1;
        end
    end

    task automatic wait_ok(input logic [3:0] mask);
        do
            @(posedge clk);
        while ((ok & mask) != mask);
    endtask

    task automatic fetch(input int s, input logic [11:0] a);
        cs[s]   = 1'b1;
        addr[s] = a;
        wait_ok(4'(1 << s));
        check_eq("fetch dout", expect_dout(s, a), dout[s]);
        #1;
        cs[s] = 1'b0;
    endtask

    task automatic random_round();
        logic [3:0] active;
        active = 4'($urandom);
        for (int s = 0; s < 4; s++) begin
            if ($urandom_range(1, 0) == 0)
                addr[s] = rand_addr(s);
            else
                addr[s] = addr[s] ^ (12'($urandom) & lane_mask(s)); // likely a hit in the same word
        end
        cs = active;
        wait_ok(active);
        #1;
        cs = '0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [11:0] a [4];
        int          n;
        void'($urandom(32'h30f7dbd8));
        rst_n       = 1'b0;
        downloading = 1'b0;
        loop_rst    = 1'b0;
        slow        = 1'b0;
        cs          = '0;
        for (int s = 0; s < 4; s++)
            addr[s] = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // one fetch per slot and then another item of the same word
        for (int s = 0; s < 4; s++) begin
            a[s] = rand_addr(s);
            fetch(s, a[s]);
            n       = req_count;
            cs[s]   = 1'b1;
            addr[s] = a[s] ^ (12'($urandom) & lane_mask(s));
            @(posedge clk);
            check_eq("hit same cycle", 32'(1), 32'(ok[s]));
            #1;
            cs[s] = 1'b0;
            @(posedge clk); // a read would show up one cycle later
            #1;
            check_eq("hit without read", n, req_count);
        end

        // all slots miss together and reads go out in slot order
        n = issued_q.size();
        for (int s = 0; s < 4; s++) begin
            a[s] = rand_addr(s);
            if (model_hit(s, a[s]))
                a[s][AW_TAB[s]-1] = ~a[s][AW_TAB[s]-1];
            addr[s] = a[s];
        end
        cs = 4'hf;
        wait_ok(4'hf);
        #1;
        cs = '0;
        for (int s = 0; s < 4; s++)
            check_eq("priority order", 32'(word_of(s, a[s])), 32'(issued_q[n + s]));

        // download drops every cached word
        for (int s = 0; s < 4; s++) begin
            a[s] = rand_addr(s);
            fetch(s, a[s]);
        end
        while (busy || sdram_req) begin
            @(posedge clk);
            #1;
        end
        downloading = 1'b1;
        @(posedge clk);
        #1;
        downloading = 1'b0;
        for (int s = 0; s < 4; s++) begin
            n       = req_count;
            cs[s]   = 1'b1;
            addr[s] = a[s];
            @(posedge clk);
            check_eq("ok low after flush", 32'(0), 32'(ok[s]));
            wait_ok(4'(1 << s));
            #1;
            cs[s] = 1'b0;
            check_eq("refetch count", n + 1, req_count);
            check_eq("refetch address", 32'(word_of(s, a[s])), 32'(issued_q[$]));
        end

        slow = 1'b1; // longest ack and data delays
        repeat (10) random_round();
        slow = 1'b0;
        repeat (40) random_round();

        @(posedge clk);
        #1;
        $display(">>> PASS");
        $finish;
    end

endmodule : tb_rom_access

`default_nettype wire

/* rom_access.f */
design/rom_pkg.sv
design/rom_slot_if.sv
design/rom_slot_req.sv
design/rom_slot_arbiter.sv
design/rom_access.sv
testbench/tb_sdram_responder.sv
testbench/tb_rom_access.sv

/* Makefile */
# verilator flow for rom_access
TOP = tb_rom_access
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rom_access.f

# the verdict comes from the log, not from the exit status
sim:
	verilator --binary --timing --top-module $(TOP) -f rom_access.f -Mdir obj_dir
	-./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
